/* hdl/isa_pkg.sv */
package isa_pkg;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        FENCE  = 7'b0001111,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        SB = 3'b000,
        SH = 3'b001,
        SW = 3'b010
    } store_funct3_t;

    localparam logic [2:0] FUNCT3_FENCEI = 3'b001;
    localparam logic [11:0] IMM_MRET = 12'h302;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Branches reuse this layout, their offset bits sit where the store immediate does.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        i_fields_t i_type;
        s_fields_t s_type;
    } instr_u;

endpackage

/* hdl/trap_pkg.sv */
package trap_pkg;

    localparam int XLEN = 32;

    typedef enum logic [2:0] {
        NONE                   = 3'd0,
        FENCEI                 = 3'd1,
        MRET                   = 3'd2,
        EBREAK                 = 3'd3,
        ECALL                  = 3'd4,
        MISALIGNED_INSTRUCTION = 3'd5,
        MISALIGNED_LOAD        = 3'd6,
        MISALIGNED_STORE       = 3'd7
    } trap_kind_t;

    // In ID addr is the branch target, from EX on it is the computed address.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [11:0]     imm;
        logic            predicted;
        logic [XLEN-1:0] addr;
    } stage_rec_t;

    typedef struct packed {
        logic            pending;
        trap_kind_t      kind;
        logic [XLEN-1:0] epc;
        logic [XLEN-1:0] tval;
    } trap_rec_t;

endpackage

/* hdl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  logic [31:0]          instr,
    input  logic [31:0]          pc,
    input  logic                 predict_taken,
    output trap_pkg::stage_rec_t id_rec
);

    isa_pkg::instr_u word;
    logic [12:0] b_offset;
    logic [11:0] j_imm;
    logic [31:0] b_target;

    assign word = instr;

    // B-type offset rebuilt from the S-type field positions.
    assign b_offset = {
        word.s_type.imm_hi[6],
        word.s_type.imm_lo[0],
        word.s_type.imm_hi[5:0],
        word.s_type.imm_lo[4:1],
        1'b0
    };

    // Low twelve bits of the J-type offset, taken from the I-type immediate field.
    assign j_imm = {word.i_type.imm[0], word.i_type.imm[10:1], 1'b0};

    assign b_target = pc + {{19{b_offset[12]}}, b_offset};

    always_comb begin
        id_rec = '0;
        id_rec.pc = pc;
        id_rec.opcode = word.i_type.opcode;
        id_rec.funct3 = word.i_type.funct3;
        id_rec.imm = word.i_type.imm;
        id_rec.predicted = predict_taken;
        case (word.i_type.opcode)
            isa_pkg::LOAD, isa_pkg::JALR, isa_pkg::FENCE, isa_pkg::SYSTEM: begin
                id_rec.valid = 1'b1;
            end
            isa_pkg::STORE: begin
                id_rec.valid = 1'b1;
                id_rec.imm = {word.s_type.imm_hi, word.s_type.imm_lo};
            end
            isa_pkg::BRANCH: begin
                id_rec.valid = 1'b1;
                id_rec.imm = b_offset[11:0];
                id_rec.addr = b_target;
            end
            isa_pkg::JAL: begin
                id_rec.valid = 1'b1;
                id_rec.imm = j_imm;
            end
            default: begin
                id_rec.valid = 1'b0; // Anything else passes through as a bubble.
            end
        endcase
    end

endmodule

/* hdl/addr_execute.sv */
`timescale 1ns/1ps

module addr_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  trap_pkg::stage_rec_t id_rec,
    input  logic [31:0]          rs1_data,
    output trap_pkg::stage_rec_t ex_rec,
    output trap_pkg::stage_rec_t mem_rec
);

    trap_pkg::stage_rec_t ex_reg;
    logic [31:0] ex_rs1;
    logic [31:0] imm_ext;

    assign imm_ext = {{20{ex_reg.imm[11]}}, ex_reg.imm};

    always_comb begin
        ex_rec = ex_reg;
        case (ex_reg.opcode)
            isa_pkg::LOAD, isa_pkg::STORE, isa_pkg::JALR: begin
                ex_rec.addr = ex_rs1 + imm_ext;
            end
            isa_pkg::JAL: begin
                ex_rec.addr = ex_reg.pc + imm_ext;
            end
            default: begin
                ex_rec.addr = ex_reg.addr; // Branch target from ID stays as it is.
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_reg <= '0;
            mem_rec <= '0;
        end else if (advance) begin
            ex_reg <= id_rec;
            mem_rec <= ex_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rs1 <= rs1_data;
        end
    end

endmodule

/* hdl/exception_detector.sv */
`timescale 1ns/1ps

module exception_detector (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  trap_pkg::stage_rec_t id_rec,
    input  trap_pkg::stage_rec_t ex_rec,
    input  trap_pkg::stage_rec_t mem_rec,
    output logic                 trapped,
    output trap_pkg::trap_kind_t trap_kind,
    output logic [31:0]          trap_epc,
    output logic [31:0]          trap_tval
);

    trap_pkg::trap_kind_t id_kind;
    trap_pkg::trap_kind_t ex_kind;
    trap_pkg::trap_kind_t mem_kind;
    trap_pkg::trap_kind_t next_kind;
    logic [31:0] next_epc;
    logic [31:0] next_tval;

    function automatic trap_pkg::trap_kind_t classify_id(input trap_pkg::stage_rec_t rec);
        trap_pkg::trap_kind_t kind;
        kind = trap_pkg::NONE;
        if (rec.valid) begin
            case (rec.opcode)
                isa_pkg::FENCE: begin
                    if (rec.funct3 == isa_pkg::FUNCT3_FENCEI) begin
                        kind = trap_pkg::FENCEI;
                    end
                end
                isa_pkg::SYSTEM: begin
                    if (rec.funct3 == 3'b000) begin
                        if (rec.imm == isa_pkg::IMM_MRET) begin
                            kind = trap_pkg::MRET;
                        end else if (rec.imm[0]) begin
                            kind = trap_pkg::EBREAK;
                        end else if (rec.imm == 12'h000) begin
                            kind = trap_pkg::ECALL;
                        end
                    end
                end
                isa_pkg::BRANCH: begin
                    if (rec.predicted && rec.addr[1:0] != 2'b00) begin
                        kind = trap_pkg::MISALIGNED_INSTRUCTION;
                    end
                end
                default: begin
                    kind = trap_pkg::NONE;
                end
            endcase
        end
        return kind;
    endfunction

    // EX and MEM apply the same alignment rules to the computed address.
    function automatic trap_pkg::trap_kind_t classify_addr(input trap_pkg::stage_rec_t rec);
        trap_pkg::trap_kind_t kind;
        kind = trap_pkg::NONE;
        if (rec.valid) begin
            case (rec.opcode)
                isa_pkg::LOAD: begin
                    if ((rec.funct3 == isa_pkg::LH || rec.funct3 == isa_pkg::LHU) && rec.addr[0])
                        kind = trap_pkg::MISALIGNED_LOAD;
                    else if (rec.funct3 == isa_pkg::LW && rec.addr[1:0] != 2'b00)
                        kind = trap_pkg::MISALIGNED_LOAD;
                end
                isa_pkg::STORE: begin
                    if (rec.funct3 == isa_pkg::SH && rec.addr[0])
                        kind = trap_pkg::MISALIGNED_STORE;
                    else if (rec.funct3 == isa_pkg::SW && rec.addr[1:0] != 2'b00)
                        kind = trap_pkg::MISALIGNED_STORE;
                end
                isa_pkg::JAL, isa_pkg::JALR: begin
                    if (rec.addr[1:0] != 2'b00) begin
                        kind = trap_pkg::MISALIGNED_INSTRUCTION;
                    end
                end
                default: begin
                    kind = trap_pkg::NONE;
                end
            endcase
        end
        return kind;
    endfunction

    assign id_kind = classify_id(id_rec);
    assign ex_kind = classify_addr(ex_rec);
    assign mem_kind = classify_addr(mem_rec);

    always_comb begin
        next_kind = trap_pkg::NONE;
        next_epc = '0;
        next_tval = '0;
        if (mem_kind != trap_pkg::NONE) begin // The oldest instruction wins.
            next_kind = mem_kind;
            next_epc = mem_rec.pc;
            next_tval = mem_rec.addr;
        end else if (ex_kind != trap_pkg::NONE) begin
            next_kind = ex_kind;
            next_epc = ex_rec.pc;
            next_tval = ex_rec.addr;
        end else if (id_kind != trap_pkg::NONE) begin
            next_kind = id_kind;
            next_epc = id_rec.pc;
            if (id_kind == trap_pkg::MISALIGNED_INSTRUCTION) begin
                next_tval = id_rec.addr;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trapped <= 1'b0;
            trap_kind <= trap_pkg::NONE;
        end else if (advance) begin
            trapped <= (next_kind != trap_pkg::NONE);
            trap_kind <= next_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            trap_epc <= next_epc;
            trap_tval <= next_tval;
        end
    end

endmodule

/* hdl/trap_csr.sv */
`timescale 1ns/1ps

module trap_csr #(
    parameter int APB_ADDR_WIDTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      trapped,
    input  trap_pkg::trap_kind_t      trap_kind,
    input  logic [31:0]               trap_epc,
    input  logic [31:0]               trap_tval,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      trap_pending
);

    localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR = APB_ADDR_WIDTH'(4'h0);
    localparam logic [APB_ADDR_WIDTH-1:0] EPC_ADDR = APB_ADDR_WIDTH'(4'h4);
    localparam logic [APB_ADDR_WIDTH-1:0] TVAL_ADDR = APB_ADDR_WIDTH'(4'h8);

    trap_pkg::trap_rec_t rec;
    logic access;
    logic addr_ok;
    logic clear;

    assign access = psel && penable;
    assign addr_ok = (paddr == STATUS_ADDR) || (paddr == EPC_ADDR) || (paddr == TVAL_ADDR);
    assign clear = access && pwrite && (paddr == STATUS_ADDR) && pwdata[0];

    assign pready = 1'b1; // No wait states.
    assign pslverr = access && !addr_ok;
    assign trap_pending = rec.pending;

    always_comb begin
        case (paddr)
            STATUS_ADDR: prdata = {28'h0, rec.kind, rec.pending};
            EPC_ADDR:    prdata = rec.epc;
            TVAL_ADDR:   prdata = rec.tval;
            default:     prdata = 32'h0;
        endcase
    end

    // Only the first trap is kept, later ones are dropped until software clears it.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rec <= '0;
        end else if (clear) begin
            rec.pending <= 1'b0;
        end else if (trapped && !rec.pending) begin
            rec.pending <= 1'b1;
            rec.kind <= trap_kind;
            rec.epc <= trap_epc;
            rec.tval <= trap_tval;
        end
    end

endmodule

/* hdl/trap_pipeline.sv */
`timescale 1ns/1ps

module trap_pipeline #(
    parameter int APB_ADDR_WIDTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      advance,
    input  logic [31:0]               instr,
    input  logic [31:0]               pc,
    input  logic [31:0]               rs1_data,
    input  logic                      predict_taken,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      trapped,
    output trap_pkg::trap_kind_t      trap_kind,
    output logic                      trap_pending
);

    trap_pkg::stage_rec_t id_rec;
    trap_pkg::stage_rec_t ex_rec;
    trap_pkg::stage_rec_t mem_rec;
    logic [31:0] trap_epc;
    logic [31:0] trap_tval;

    instr_decode instr_decode_inst (
        .instr(instr),
        .pc(pc),
        .predict_taken(predict_taken),
        .id_rec(id_rec)
    );

    addr_execute addr_execute_inst (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .id_rec(id_rec),
        .rs1_data(rs1_data),
        .ex_rec(ex_rec),
        .mem_rec(mem_rec)
    );

    exception_detector exception_detector_inst (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .id_rec(id_rec),
        .ex_rec(ex_rec),
        .mem_rec(mem_rec),
        .trapped(trapped),
        .trap_kind(trap_kind),
        .trap_epc(trap_epc),
        .trap_tval(trap_tval)
    );

    trap_csr #(
        .APB_ADDR_WIDTH(APB_ADDR_WIDTH)
    ) trap_csr_inst (
        .clk(clk),
        .reset(reset),
        .trapped(trapped),
        .trap_kind(trap_kind),
        .trap_epc(trap_epc),
        .trap_tval(trap_tval),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .trap_pending(trap_pending)
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 4; // 8 ns clock period.
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* bench/trap_pipeline_tb.sv */
`timescale 1ns/1ps

module trap_pipeline_tb;

    localparam int APB_ADDR_WIDTH = 4;
    localparam int MAX_CYCLES = 3000; // The whole sequence takes about 1100 cycles.
    localparam logic [31:0] NOP = 32'h0000_0013; // ADDI decodes as a bubble here.
    localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR = APB_ADDR_WIDTH'(4'h0);
    localparam logic [APB_ADDR_WIDTH-1:0] EPC_ADDR = APB_ADDR_WIDTH'(4'h4);
    localparam logic [APB_ADDR_WIDTH-1:0] TVAL_ADDR = APB_ADDR_WIDTH'(4'h8);
    localparam logic [APB_ADDR_WIDTH-1:0] UNMAPPED_ADDR = APB_ADDR_WIDTH'(4'hC);

    logic clk;
    logic reset;
    logic advance;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic predict_taken;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic trapped;
    trap_pkg::trap_kind_t trap_kind;
    logic trap_pending;

    int error_count = 0;
    int cycle_count = 0;
    logic [31:0] rng_state;
    logic [31:0] next_pc;

    clock_gen clock_gen_inst (
        .clk(clk),
        .reset(reset)
    );

    trap_pipeline #(
        .APB_ADDR_WIDTH(APB_ADDR_WIDTH)
    ) trap_pipeline_inst (.*);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests were still running after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] i_type_word(input isa_pkg::opcode_t op, input logic [2:0] f3,
                                                input logic [11:0] imm);
        isa_pkg::instr_u w;
        w = '0;
        w.i_type.opcode = op;
        w.i_type.funct3 = f3;
        w.i_type.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] s_type_word(input logic [2:0] f3, input logic [11:0] imm);
        isa_pkg::instr_u w;
        w = '0;
        w.s_type.opcode = isa_pkg::STORE;
        w.s_type.funct3 = f3;
        w.s_type.imm_hi = imm[11:5];
        w.s_type.imm_lo = imm[4:0];
        return w;
    endfunction

    // BEQ, with the B-type offset scattered over the S-type immediate fields.
    function automatic logic [31:0] branch_word(input logic [12:0] off);
        isa_pkg::instr_u w;
        w = '0;
        w.s_type.opcode = isa_pkg::BRANCH;
        w.s_type.imm_hi = {off[12], off[10:5]};
        w.s_type.imm_lo = {off[4:1], off[11]};
        return w;
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off);
        isa_pkg::instr_u w;
        w = '0;
        w.i_type.opcode = isa_pkg::JAL;
        w.i_type.rd = 5'd1;
        w.i_type.imm = {off[20], off[10:1], off[11]};
        w.i_type.rs1 = off[19:15];
        w.i_type.funct3 = off[14:12];
        return w;
    endfunction

    task automatic check_kind(input string name, input trap_pkg::trap_kind_t exp,
                              input trap_pkg::trap_kind_t act);
        if (exp !== act) begin
            error_count++;
            $display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            error_count++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        paddr <= addr;
        pwrite <= 1'b0;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata; // Access cycle.
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        paddr <= addr;
        pwrite <= 1'b1;
        pwdata <= data;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic issue(input logic [31:0] word, input logic [31:0] at_pc,
                         input logic [31:0] rs1, input logic taken);
        @(posedge clk);
        instr <= word;
        pc <= at_pc;
        rs1_data <= rs1;
        predict_taken <= taken;
    endtask

    task automatic drain(input int edges);
        repeat (edges) begin
            @(posedge clk);
            instr <= NOP;
            predict_taken <= 1'b0;
        end
    endtask

    task automatic verify_record(input string name, input trap_pkg::trap_kind_t exp_kind,
                                 input logic [31:0] exp_epc, input logic [31:0] exp_tval,
                                 input logic clear);
        logic [31:0] data;
        logic err;
        logic exp_pending;
        exp_pending = (exp_kind != trap_pkg::NONE);
        @(negedge clk);
        check_bit({name, " trap_pending"}, exp_pending, trap_pending);
        apb_read(STATUS_ADDR, data, err);
        check_bit({name, " status pending"}, exp_pending, data[0]);
        check_bit({name, " pslverr"}, 1'b0, err);
        if (exp_pending) begin
            check_kind({name, " kind"}, exp_kind, trap_pkg::trap_kind_t'(data[3:1]));
            apb_read(EPC_ADDR, data, err);
            check_word({name, " epc"}, exp_epc, data);
            apb_read(TVAL_ADDR, data, err);
            check_word({name, " tval"}, exp_tval, data);
        end
        if (clear) begin
            apb_write(STATUS_ADDR, 32'h1, err);
            @(negedge clk);
            check_bit({name, " cleared"}, 1'b0, trap_pending);
        end
    endtask

    task automatic run_instr(input string name, input logic [31:0] word, input logic [31:0] rs1,
                             input logic taken, input trap_pkg::trap_kind_t exp_kind,
                             input logic [31:0] exp_tval);
        issue(word, next_pc, rs1, taken);
        drain(5); // Enough for a trap caught in MEM to reach the record.
        verify_record(name, exp_kind, next_pc, exp_tval, 1'b1);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic apb_reset_values();
        logic [31:0] data;
        logic err;
        @(negedge clk);
        check_bit("reset trapped", 1'b0, trapped);
        check_kind("reset trap_kind", trap_pkg::NONE, trap_kind);
        check_bit("reset trap_pending", 1'b0, trap_pending);
        check_bit("reset pslverr", 1'b0, pslverr);
        check_bit("pready", 1'b1, pready);
        apb_read(STATUS_ADDR, data, err);
        check_word("reset status", 32'h0, data);
        apb_read(UNMAPPED_ADDR, data, err);
        check_bit("unmapped pslverr", 1'b1, err);
    endtask

    task automatic system_traps();
        run_instr("fence.i", i_type_word(isa_pkg::FENCE, isa_pkg::FUNCT3_FENCEI, 12'h0),
                  32'h0, 1'b0, trap_pkg::FENCEI, 32'h0);
        run_instr("ecall", i_type_word(isa_pkg::SYSTEM, 3'b000, 12'h000),
                  32'h0, 1'b0, trap_pkg::ECALL, 32'h0);
        run_instr("ebreak", i_type_word(isa_pkg::SYSTEM, 3'b000, 12'h001),
                  32'h0, 1'b0, trap_pkg::EBREAK, 32'h0);
        run_instr("mret", i_type_word(isa_pkg::SYSTEM, 3'b000, isa_pkg::IMM_MRET),
                  32'h0, 1'b0, trap_pkg::MRET, 32'h0);
        run_instr("fence", i_type_word(isa_pkg::FENCE, 3'b000, 12'h0),
                  32'h0, 1'b0, trap_pkg::NONE, 32'h0);
    endtask

    task automatic load_store_alignment(input string name, input logic is_store,
                                        input logic [2:0] f3, input int width);
        logic [11:0] imm;
        logic [31:0] addr;
        logic [31:0] rs1;
        logic [31:0] word;
        trap_pkg::trap_kind_t kind;
        int i;
        for (i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            imm = rng_state[11:0];
            rng_state = xorshift32(rng_state);
            addr = {rng_state[31:2], 2'(i)}; // Each pass lands on another byte offset.
            rs1 = addr - sext12(imm);
            if (is_store)
                word = s_type_word(f3, imm);
            else
                word = i_type_word(isa_pkg::LOAD, f3, imm);
            kind = trap_pkg::NONE;
            if ((addr % width) != 0)
                kind = is_store ? trap_pkg::MISALIGNED_STORE : trap_pkg::MISALIGNED_LOAD;
            run_instr($sformatf("%s %0d", name, i), word, rs1, 1'b0, kind, addr);
        end
    endtask

    task automatic jump_targets();
        // EX keeps only 12 bits of the JAL offset, so the offsets stay small.
        logic [20:0] jal_off [3] = '{21'h000100, 21'h000102, 21'h1ffffa};
        logic [11:0] imm;
        logic [31:0] target;
        logic [31:0] rs1;
        trap_pkg::trap_kind_t kind;
        int i;
        for (i = 0; i < 3; i++) begin
            target = next_pc + {{11{jal_off[i][20]}}, jal_off[i]};
            kind = ((target % 4) != 0) ? trap_pkg::MISALIGNED_INSTRUCTION : trap_pkg::NONE;
            run_instr($sformatf("jal %0d", i), jal_word(jal_off[i]), 32'h0, 1'b0, kind, target);
        end
        for (i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            imm = rng_state[11:0];
            rng_state = xorshift32(rng_state);
            target = {rng_state[31:2], 2'(i)};
            rs1 = target - sext12(imm);
            kind = ((target % 4) != 0) ? trap_pkg::MISALIGNED_INSTRUCTION : trap_pkg::NONE;
            run_instr($sformatf("jalr %0d", i), i_type_word(isa_pkg::JALR, 3'b000, imm),
                      rs1, 1'b0, kind, target);
        end
    endtask

    task automatic branch_predictions();
        logic [12:0] br_off [4] = '{13'h0040, 13'h0042, 13'h0042, 13'h1ffe};
        logic br_taken [4] = '{1'b1, 1'b0, 1'b1, 1'b1};
        logic [31:0] target;
        trap_pkg::trap_kind_t kind;
        int i;
        for (i = 0; i < 4; i++) begin
            target = next_pc + {{19{br_off[i][12]}}, br_off[i]};
            kind = trap_pkg::NONE;
            if (br_taken[i] && (target % 4) != 0)
                kind = trap_pkg::MISALIGNED_INSTRUCTION;
            run_instr($sformatf("branch %0d", i), branch_word(br_off[i]), 32'h0, br_taken[i],
                      kind, target);
        end
    endtask

    task automatic oldest_trap_wins();
        logic [31:0] lw_pc;
        logic [31:0] lw_addr;
        logic [31:0] ecall;
        lw_pc = next_pc;
        lw_addr = 32'h0000_2005;
        ecall = i_type_word(isa_pkg::SYSTEM, 3'b000, 12'h000);
        issue(i_type_word(isa_pkg::LOAD, isa_pkg::LW, 12'h004), lw_pc, 32'h0000_2001, 1'b0);
        issue(ecall, lw_pc + 32'd4, 32'h0, 1'b0); // Right behind the load.
        drain(5);
        verify_record("lw before ecall", trap_pkg::MISALIGNED_LOAD, lw_pc, lw_addr, 1'b0);
        issue(ecall, lw_pc + 32'd8, 32'h0, 1'b0);
        drain(5);
        verify_record("ecall while pending", trap_pkg::MISALIGNED_LOAD, lw_pc, lw_addr, 1'b1);
        next_pc = lw_pc + 32'd12;
        run_instr("ecall after clear", ecall, 32'h0, 1'b0, trap_pkg::ECALL, 32'h0);
    endtask

    task automatic stall_holds();
        logic [31:0] at_pc;
        logic seen;
        int i;
        at_pc = next_pc;
        next_pc = next_pc + 32'd4;
        @(posedge clk);
        instr <= i_type_word(isa_pkg::SYSTEM, 3'b000, 12'h000);
        pc <= at_pc;
        advance <= 1'b0;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_bit("stall trapped", 1'b0, trapped);
            check_bit("stall trap_pending", 1'b0, trap_pending);
        end
        @(posedge clk);
        advance <= 1'b1;
        seen = 1'b0;
        for (i = 0; i < 5; i++) begin
            @(posedge clk);
            instr <= NOP;
            @(negedge clk);
            if (trapped) begin
                seen = 1'b1;
                check_kind("stall trap_kind", trap_pkg::ECALL, trap_kind);
            end
        end
        check_bit("stall trap after resume", 1'b1, seen);
        verify_record("stall ecall", trap_pkg::ECALL, at_pc, 32'h0, 1'b1);
    endtask

    task automatic status_clear();
        logic [31:0] data;
        logic err;
        issue(i_type_word(isa_pkg::SYSTEM, 3'b000, 12'h001), next_pc, 32'h0, 1'b0);
        next_pc = next_pc + 32'd4;
        drain(5);
        @(negedge clk);
        check_bit("status set", 1'b1, trap_pending);
        apb_write(STATUS_ADDR, 32'h0, err); // Bit 0 low leaves the record alone.
        @(negedge clk);
        check_bit("status kept", 1'b1, trap_pending);
        apb_write(STATUS_ADDR, 32'h1, err);
        check_bit("status write pslverr", 1'b0, err);
        @(negedge clk);
        check_bit("status cleared", 1'b0, trap_pending);
        apb_read(STATUS_ADDR, data, err);
        check_bit("status pending bit", 1'b0, data[0]);
    endtask

    initial begin
        advance = 1'b1;
        instr = NOP;
        pc = 32'h0;
        rs1_data = 32'h0;
        predict_taken = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'h0;
        rng_state = 32'h0eaf99e2;
        next_pc = 32'h0000_1000;
        wait (reset == 1'b0);
        apb_reset_values();
        system_traps();
        load_store_alignment("lb", 1'b0, isa_pkg::LB, 1);
        load_store_alignment("lbu", 1'b0, isa_pkg::LBU, 1);
        load_store_alignment("lh", 1'b0, isa_pkg::LH, 2);
        load_store_alignment("lhu", 1'b0, isa_pkg::LHU, 2);
        load_store_alignment("lw", 1'b0, isa_pkg::LW, 4);
        load_store_alignment("sb", 1'b1, isa_pkg::SB, 1);
        load_store_alignment("sh", 1'b1, isa_pkg::SH, 2);
        load_store_alignment("sw", 1'b1, isa_pkg::SW, 4);
        jump_targets();
        branch_predictions();
        oldest_trap_wins();
        stall_holds();
        status_clear();
        $display("Tests finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/isa_pkg.sv
hdl/trap_pkg.sv
hdl/instr_decode.sv
hdl/addr_execute.sv
hdl/exception_detector.sv
hdl/trap_csr.sv
hdl/trap_pipeline.sv
bench/clock_gen.sv
bench/trap_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module trap_pipeline_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtrap_pipeline_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
